// File: verilog.f
videoTimingPkg.sv
tileMapPkg.sv
rasterCounter.sv
scrollRegisters.sv
tileFetchSequencer.sv
tileAddressGen.sv
tileMapGen.sv
tileMapGenTb.sv

// File: Bender.yml
package:
  name: tileMapGen

sources:
  - videoTimingPkg.sv
  - tileMapPkg.sv
  - rasterCounter.sv
  - scrollRegisters.sv
  - tileFetchSequencer.sv
  - tileAddressGen.sv
  - tileMapGen.sv
  - target: test
    files:
      - tileMapGenTb.sv

// File: tileMapGenTb.sv
`timescale 1ns/1ns

module tileMapGenTb
	import videoTimingPkg::*;
	import tileMapPkg::*;
;

	// 4 frames of 6 lines of 128 clocks plus slack
	localparam int cycleLimit = 4 * 6 * 128 + 500;

	logic        CLK_6M;
	logic        arstN;
	logic        hSync;
	logic        vSync;
	logic        cpuWrite;
	logic [2:0]  cpuAddr;
	logic [7:0]  cpuData;
	logic [7:0]  ramData;
	tileRamAddrT ramAddr;
	gfxAddrT     gfxAddr;
	logic        strobeA;
	logic        strobeB;
	logic        gfxLayer;
	logic [2:0]  layerPri;

	// sync generator
	logic [6:0] lineCyc;
	logic [2:0] lineNum;

	// reference model state
	logic                    hSyncD;
	logic                    vSyncD;
	logic                    hEdge;
	logic                    vEdge;
	logic [hBits-1:0]        hRef;
	logic [vBits-1:0]        vRef;
	scrollRegT               shadowScroll [2];
	logic [tileCodeBits-1:0] codeRef [2];
	logic [2:0]              phaseRef;
	logic [hBits-1:0]        hScrollRef [2];
	logic [vBits-1:0]        vScrollRef [2];
	tileRamAddrT             expRam;
	tileRamAddrT             resetAddr;
	logic [7:0]              ramRef;
	gfxAddrT                 expGfx;
	logic [2:0]              expPri;
	logic [7:0]              vOffNow;
	// expectations one clock after the slot
	logic                    slotQ;
	logic                    layQ;
	logic                    nibQ;
	logic                    vZeroQ;
	gfxAddrT                 expGfxQ;
	logic [2:0]              expPriQ;
	logic [7:0]              vOffQ;

	logic        anyWrite;
	logic [31:0] lcgState;
	string       testName;
	int          cycles = 0;

	tileMapGen dut_i (
		.CLK_6M   (CLK_6M),
		.arstN    (arstN),
		.hSync    (hSync),
		.vSync    (vSync),
		.cpuWrite (cpuWrite),
		.cpuAddr  (cpuAddr),
		.cpuData  (cpuData),
		.ramData  (ramData),
		.ramAddr  (ramAddr),
		.gfxAddr  (gfxAddr),
		.strobeA  (strobeA),
		.strobeB  (strobeB),
		.gfxLayer (gfxLayer),
		.layerPri (layerPri)
	);

	initial begin
		CLK_6M = 1'b0;
		forever #4 CLK_6M = ~CLK_6M;
	end

	// tile ram contents are the low byte times 37 mixed with the upper bits
	function automatic logic [7:0] ramFn(input tileRamAddrT a);
		logic [7:0] prod;
		prod = a[7:0] * 8'd37;
		return prod ^ {3'b000, a[12:8]};
	endfunction

	function automatic logic [7:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[23:16];
	endfunction

	// ram answers in the same cycle
	always_comb ramData = ramFn(ramAddr);

	task automatic reportFail();
		$display("Finished with errors");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////
	// sync pulses for 128 clock lines and 6 line frames
	//////////////////////////////////////////////////

	always @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			lineCyc <= '0;
			lineNum <= '0;
			hSync   <= 1'b0;
			vSync   <= 1'b0;
		end else begin
			lineCyc <= lineCyc + 1'b1;
			if (lineCyc == 7'd127)
				lineNum <= (lineNum == 3'd5) ? 3'd0 : lineNum + 1'b1;
			hSync <= (lineCyc < 7'd4);
			vSync <= (lineCyc < 7'd4) && (lineNum == 3'd0);
		end
	end

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	// edge seen one clock after the pin and counters move on the next
	always @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			{hSyncD, vSyncD, hEdge, vEdge} <= '0;
			hRef <= '0;
			vRef <= '0;
		end else begin
			hSyncD <= hSync;
			vSyncD <= vSync;
			hEdge  <= hSync && !hSyncD;
			vEdge  <= vSync && !vSyncD;
			hRef   <= hEdge ? '0 : hRef + 1'b1;
			if (vEdge)
				vRef <= '0;
			else if (hEdge)
				vRef <= vRef + 1'b1;
		end
	end

	always_comb begin
		phaseRef = hRef[2:0];
		for (int i = 0; i < 2; i++) begin
			hScrollRef[i] = hRef + shadowScroll[i].hOffset;
			vScrollRef[i] = vRef + shadowScroll[i].vOffset;
		end
		// phases 0..3 walk layer then byte
		expRam.layer   = phaseRef[1];
		expRam.row     = vScrollRef[phaseRef[1]][7:3];
		expRam.column  = hScrollRef[phaseRef[1]][8:3];
		expRam.byteSel = phaseRef[0];
		resetAddr      = {1'b0, vRef[7:3], hRef[8:3], 1'b0};
		ramRef         = ramFn(expRam);
		// phases 4..7 pick layer and nibble the same way
		expGfx.tileCode = codeRef[phaseRef[1]];
		expGfx.fineRow  = vScrollRef[phaseRef[1]][2:0];
		expGfx.nibble   = phaseRef[0];
		expPri          = shadowScroll[phaseRef[1]].pri;
		vOffNow         = shadowScroll[phaseRef[1]].vOffset;
	end

	always @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			codeRef[0] <= '0;
			codeRef[1] <= '0;
			{slotQ, layQ, nibQ, vZeroQ} <= '0;
			expGfxQ <= '0;
			expPriQ <= '0;
			vOffQ   <= '0;
		end else begin
			if (!phaseRef[2]) begin
				if (!phaseRef[0])
					codeRef[phaseRef[1]][7:0] <= ramRef;
				else
					codeRef[phaseRef[1]][9:8] <= ramRef[1:0];
			end
			slotQ   <= phaseRef[2];
			layQ    <= phaseRef[1];
			nibQ    <= phaseRef[0];
			vZeroQ  <= (vRef == '0);
			expGfxQ <= expGfx;
			expPriQ <= expPri;
			vOffQ   <= vOffNow;
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	aResetStrobe: assert property (@(posedge CLK_6M)
		(!arstN && cycles > 0) |-> (!strobeA && !strobeB))
	else begin
		$display("mismatch %s strobes expected 00 actual %b%b", testName,
			$sampled(strobeA), $sampled(strobeB));
		reportFail();
	end

	aResetAddr: assert property (@(posedge CLK_6M) disable iff (!arstN)
		(phaseRef == 3'd0 && !anyWrite) |-> ramAddr == resetAddr)
	else begin
		$display("mismatch %s ramAddr expected %h actual %h", testName,
			$sampled(resetAddr), $sampled(ramAddr));
		reportFail();
	end

	aRamAddr: assert property (@(posedge CLK_6M) disable iff (!arstN)
		!phaseRef[2] |-> ramAddr == expRam)
	else begin
		$display("mismatch %s ramAddr expected %h actual %h", testName,
			$sampled(expRam), $sampled(ramAddr));
		reportFail();
	end

	aGfxAddr: assert property (@(posedge CLK_6M) disable iff (!arstN)
		slotQ |-> (gfxAddr == expGfxQ && gfxLayer == layQ))
	else begin
		$display("mismatch %s gfxAddr expected %h/%b actual %h/%b", testName,
			$sampled(expGfxQ), $sampled(layQ), $sampled(gfxAddr), $sampled(gfxLayer));
		reportFail();
	end

	aStrobes: assert property (@(posedge CLK_6M) disable iff (!arstN)
		strobeA == (slotQ && !nibQ) && strobeB == (slotQ && nibQ))
	else begin
		$display("mismatch %s strobes expected %b%b actual %b%b", testName,
			$sampled(slotQ && !nibQ), $sampled(slotQ && nibQ),
			$sampled(strobeA), $sampled(strobeB));
		reportFail();
	end

	aLayerPri: assert property (@(posedge CLK_6M) disable iff (!arstN)
		slotQ |-> layerPri == expPriQ)
	else begin
		$display("mismatch %s layerPri expected %h actual %h", testName,
			$sampled(expPriQ), $sampled(layerPri));
		reportFail();
	end

	// on the first line of a frame vScroll is just the offset
	aWrapRow: assert property (@(posedge CLK_6M) disable iff (!arstN)
		(vRef == '0 && !phaseRef[2]) |-> ramAddr.row == vOffNow[7:3])
	else begin
		$display("mismatch %s row expected %h actual %h", testName,
			$sampled(vOffNow[7:3]), $sampled(ramAddr.row));
		reportFail();
	end

	aWrapFine: assert property (@(posedge CLK_6M) disable iff (!arstN)
		(slotQ && vZeroQ) |-> gfxAddr.fineRow == vOffQ[2:0])
	else begin
		$display("mismatch %s fineRow expected %h actual %h", testName,
			$sampled(vOffQ[2:0]), $sampled(gfxAddr.fineRow));
		reportFail();
	end

	always @(posedge CLK_6M) begin
		cycles <= cycles + 1;
		if (cycles == cycleLimit) begin
			$display("timeout: tests did not complete");
			reportFail();
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	// register takes the value at the edge after the strobe
	task automatic writeReg(input logic [2:0] addr, input logic [7:0] data);
		@(posedge CLK_6M);
		cpuWrite <= 1'b1;
		cpuAddr  <= addr;
		cpuData  <= data;
		@(posedge CLK_6M);
		cpuWrite <= 1'b0;
		anyWrite <= 1'b1;
		case (addr[1:0])
			2'd0: shadowScroll[addr[2]].hOffset[7:0] <= data;
			2'd1: begin
				shadowScroll[addr[2]].hOffset[8] <= data[0];
				shadowScroll[addr[2]].pri        <= data[3:1];
			end
			2'd2: shadowScroll[addr[2]].vOffset <= data;
			default: begin
				// no register at field 3
			end
		endcase
	endtask

	task automatic runLines(input int n);
		repeat (n) @(posedge hSync);
	endtask

	initial begin
		arstN           = 1'b0;
		cpuWrite        = 1'b0;
		cpuAddr         = '0;
		cpuData         = '0;
		anyWrite        = 1'b0;
		lcgState        = 32'd24;
		shadowScroll[0] = '0;
		shadowScroll[1] = '0;
		testName        = "reset";
		repeat (3) @(posedge CLK_6M);
		arstN <= 1'b1;
		runLines(6);

		// all three field codes on both layers
		testName = "scroll";
		for (int l = 0; l < 2; l++) begin
			writeReg({l[0], 2'd0}, nextRand());
			writeReg({l[0], 2'd1}, nextRand());
			writeReg({l[0], 2'd2}, nextRand());
		end
		runLines(6);

		// new priorities then writes to the unused field
		testName = "priority";
		writeReg(3'd1, nextRand());
		writeReg(3'd5, nextRand());
		writeReg(3'd3, nextRand());
		writeReg(3'd7, nextRand());
		runLines(6);

		// offsets near the top force the 8 bit wrap
		testName = "vwrap";
		writeReg(3'd2, nextRand() | 8'hFC);
		writeReg(3'd6, nextRand() | 8'hFC);
		runLines(6);

		@(negedge CLK_6M);
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: tileMapGen.sv
`timescale 1ns/1ns

module tileMapGen
	import videoTimingPkg::*;
	import tileMapPkg::*;
(
	input  logic        CLK_6M,
	input  logic        arstN,
	input  logic        hSync,
	input  logic        vSync,
	input  logic        cpuWrite,
	input  logic [2:0]  cpuAddr,
	input  logic [7:0]  cpuData,
	input  logic [7:0]  ramData,
	output tileRamAddrT ramAddr,
	output gfxAddrT     gfxAddr,
	output logic        strobeA,
	output logic        strobeB,
	output logic        gfxLayer,
	output logic [2:0]  layerPri
);

	//////////////////////////////////////////////////
	// internal nets
	//////////////////////////////////////////////////

	rasterPosT pos;
	scrollRegT scroll [2];
	fetchCtlT  ctl;

	// beam position from sync pulses
	rasterCounter rasterCounterInst (
		.CLK_6M (CLK_6M),
		.arstN  (arstN),
		.hSync  (hSync),
		.vSync  (vSync),
		.pos    (pos)
	);

	// cpu scroll and priority registers
	scrollRegisters scrollRegistersInst (
		.CLK_6M   (CLK_6M),
		.arstN    (arstN),
		.cpuWrite (cpuWrite),
		.cpuAddr  (cpuAddr),
		.cpuData  (cpuData),
		.scroll   (scroll)
	);

	// 8 clock fetch schedule
	tileFetchSequencer tileFetchSequencerInst (
		.CLK_6M (CLK_6M),
		.arstN  (arstN),
		.pos    (pos),
		.ctl    (ctl)
	);

	// ram and rom address datapath
	tileAddressGen tileAddressGenInst (
		.CLK_6M   (CLK_6M),
		.arstN    (arstN),
		.pos      (pos),
		.scroll   (scroll),
		.ctl      (ctl),
		.ramData  (ramData),
		.ramAddr  (ramAddr),
		.gfxAddr  (gfxAddr),
		.gfxLayer (gfxLayer),
		.layerPri (layerPri),
		.strobeA  (strobeA),
		.strobeB  (strobeB)
	);

endmodule

// File: tileAddressGen.sv
`timescale 1ns/1ns

module tileAddressGen
	import videoTimingPkg::*;
	import tileMapPkg::*;
(
	input  logic        CLK_6M,
	input  logic        arstN,
	input  rasterPosT   pos,
	input  scrollRegT   scroll [2],
	input  fetchCtlT    ctl,
	input  logic [7:0]  ramData,
	output tileRamAddrT ramAddr,
	output gfxAddrT     gfxAddr,
	output logic        gfxLayer,
	output logic [2:0]  layerPri,
	output logic        strobeA,
	output logic        strobeB
);

	// per layer tilemap position
	logic [hBits-1:0] hScroll [2];
	logic [vBits-1:0] vScroll [2];

	// tile code latches
	logic [tileCodeBits-1:0] tileCode [2];

	//////////////////////////////////////////////////
	// scroll add
	//////////////////////////////////////////////////

	// natural wrap, 512 wide and 256 high
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			hScroll[i] = pos.hCount + scroll[i].hOffset;
			vScroll[i] = pos.vCount + scroll[i].vOffset;
		end
	end

	// ram address for the layer and byte in this phase
	assign ramAddr.layer   = ctl.ramLayer;
	assign ramAddr.row     = vScroll[ctl.ramLayer][vBits-1:tileShift];
	assign ramAddr.column  = hScroll[ctl.ramLayer][hBits-1:tileShift];
	assign ramAddr.byteSel = ctl.ramByte;

	//////////////////////////////////////////////////
	// tile code capture
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			tileCode[0] <= '0;
			tileCode[1] <= '0;
		end else begin
			// byte 0 is the low 8 bits of the code
			if (ctl.capLo)
				tileCode[ctl.ramLayer][7:0] <= ramData;
			// byte 1, only the bottom two bits are code
			if (ctl.capHi)
				tileCode[ctl.ramLayer][tileCodeBits-1:8] <= ramData[1:0];
		end
	end

	//////////////////////////////////////////////////
	// rom address and strobes
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			gfxAddr  <= '0;
			gfxLayer <= 1'b0;
			layerPri <= '0;
			strobeA  <= 1'b0;
			strobeB  <= 1'b0;
		end else begin
			// strobes are single cycle pulses
			strobeA <= ctl.gfxValid & ~ctl.gfxNibble;
			strobeB <= ctl.gfxValid & ctl.gfxNibble;
			// address and layer hold between slots
			if (ctl.gfxValid) begin
				gfxAddr.tileCode <= tileCode[ctl.gfxLayer];
				gfxAddr.fineRow  <= vScroll[ctl.gfxLayer][tileShift-1:0];
				gfxAddr.nibble   <= ctl.gfxNibble;
				gfxLayer         <= ctl.gfxLayer;
				layerPri         <= scroll[ctl.gfxLayer].pri;
			end
		end
	end

endmodule

// File: tileFetchSequencer.sv
`timescale 1ns/1ns

module tileFetchSequencer
	import videoTimingPkg::*;
	import tileMapPkg::*;
(
	input  logic      CLK_6M,
	input  logic      arstN,
	input  rasterPosT pos,
	output fetchCtlT  ctl
);

	// one state per pixel of the tile, ram reads then rom slots
	typedef enum logic [tileShift-1:0] {
		sRamL0B0,
		sRamL0B1,
		sRamL1B0,
		sRamL1B1,
		sGfxL0N0,
		sGfxL0N1,
		sGfxL1N0,
		sGfxL1N1
	} phaseT;

	phaseT state;
	phaseT curPhase;
	logic  lineStart;

	//////////////////////////////////////////////////
	// phase tracking
	//////////////////////////////////////////////////

	// h counter restarts on sync, so snap back to its phase
	assign lineStart = (pos.hCount == '0);
	assign curPhase  = lineStart ? phaseT'(pos.hCount[tileShift-1:0]) : state;

	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN)
			state <= sRamL0B0;
		else
			state <= phaseT'(curPhase + 1'b1);
	end

	//////////////////////////////////////////////////
	// steering word per phase
	//////////////////////////////////////////////////

	always_comb begin
		ctl = '0;
		case (curPhase)
			// tile code low byte, layer 0
			sRamL0B0: begin
				ctl.capLo = 1'b1;
			end
			sRamL0B1: begin
				ctl.ramByte = 1'b1;
				ctl.capHi   = 1'b1;
			end
			sRamL1B0: begin
				ctl.ramLayer = 1'b1;
				ctl.capLo    = 1'b1;
			end
			sRamL1B1: begin
				ctl.ramLayer = 1'b1;
				ctl.ramByte  = 1'b1;
				ctl.capHi    = 1'b1;
			end
			// rom slots, ram address parks on layer 0 byte 0
			sGfxL0N0: begin
				ctl.gfxValid = 1'b1;
			end
			sGfxL0N1: begin
				ctl.gfxValid  = 1'b1;
				ctl.gfxNibble = 1'b1;
			end
			sGfxL1N0: begin
				ctl.gfxValid = 1'b1;
				ctl.gfxLayer = 1'b1;
			end
			sGfxL1N1: begin
				ctl.gfxValid  = 1'b1;
				ctl.gfxLayer  = 1'b1;
				ctl.gfxNibble = 1'b1;
			end
			default: begin
				ctl = '0;
			end
		endcase
	end

endmodule

// File: scrollRegisters.sv
`timescale 1ns/1ns

module scrollRegisters
	import videoTimingPkg::*;
	import tileMapPkg::*;
(
	input  logic       CLK_6M,
	input  logic       arstN,
	input  logic       cpuWrite,
	input  logic [2:0] cpuAddr,
	input  logic [7:0] cpuData,
	output scrollRegT  scroll [2]
);

	// register map
	//   addr[2]    layer
	//   addr[1:0]  0 hOffset low byte
	//              1 hOffset msb in d0, pri in d3..d1
	//              2 vOffset
	//              3 unused

	logic       layerSel;
	logic [1:0] fieldSel;

	scrollRegT regs [2];

	assign layerSel = cpuAddr[2];
	assign fieldSel = cpuAddr[1:0];

	//////////////////////////////////////////////////
	// cpu write decode
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			regs[0] <= '0;
			regs[1] <= '0;
		end else if (cpuWrite) begin
			case (fieldSel)
				2'd0: begin
					regs[layerSel].hOffset[hBits-2:0] <= cpuData;
				end
				2'd1: begin
					// 9th scroll bit shares the byte with priority
					regs[layerSel].hOffset[hBits-1] <= cpuData[0];
					regs[layerSel].pri              <= cpuData[3:1];
				end
				2'd2: begin
					regs[layerSel].vOffset <= cpuData[vBits-1:0];
				end
				default: begin
					// field 3 has no register behind it
				end
			endcase
		end
	end

	// new values visible the cycle after the write
	assign scroll[0] = regs[0];
	assign scroll[1] = regs[1];

endmodule

// File: rasterCounter.sv
`timescale 1ns/1ns

module rasterCounter
	import videoTimingPkg::*;
(
	input  logic      CLK_6M,
	input  logic      arstN,
	input  logic      hSync,
	input  logic      vSync,
	output rasterPosT pos
);

	// sync pins, one register stage
	logic hSyncQ;
	logic vSyncQ;

	// rising edge flags, high one cycle after the pin rises
	logic hRise;
	logic vRise;

	logic [hBits-1:0] hCount;
	logic [vBits-1:0] vCount;

	//////////////////////////////////////////////////
	// sync edge detect
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			hSyncQ <= 1'b0;
			vSyncQ <= 1'b0;
			hRise  <= 1'b0;
			vRise  <= 1'b0;
		end else begin
			hSyncQ <= hSync;
			vSyncQ <= vSync;
			// pin high now, low last cycle
			hRise  <= hSync & ~hSyncQ;
			vRise  <= vSync & ~vSyncQ;
		end
	end

	//////////////////////////////////////////////////
	// pixel and line counters
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			hCount <= '0;
			vCount <= '0;
		end else begin
			// new line restarts h, otherwise free running
			if (hRise)
				hCount <= '0;
			else
				hCount <= hCount + 1'b1;

			// frame start wins over the line step
			if (vRise)
				vCount <= '0;
			else if (hRise)
				vCount <= vCount + 1'b1;
		end
	end

	assign pos.hCount = hCount;
	assign pos.vCount = vCount;

endmodule

// File: tileMapPkg.sv
package tileMapPkg;

	//////////////////////////////////////////////////
	// cpu side layer settings
	//////////////////////////////////////////////////

	// tile code width, 1024 tiles in gfx rom
	localparam int tileCodeBits = 10;

	// one scrolling layer
	typedef struct packed {
		logic [8:0] hOffset;
		logic [7:0] vOffset;
		// priority, passed through to the mixer
		logic [2:0] pri;
	} scrollRegT;

	//////////////////////////////////////////////////
	// memory addresses
	//////////////////////////////////////////////////

	// tile ram, 2 layers of 64x32 tiles, 2 bytes per tile
	typedef struct packed {
		logic       layer;
		logic [4:0] row;
		logic [5:0] column;
		logic       byteSel;
	} tileRamAddrT;

	// gfx rom, one byte holds two 4bpp pixels of a row
	typedef struct packed {
		logic [tileCodeBits-1:0] tileCode;
		logic [2:0]              fineRow;
		logic                    nibble;
	} gfxAddrT;

	//////////////////////////////////////////////////
	// sequencer steering word
	//////////////////////////////////////////////////

	typedef struct packed {
		// ram address select
		logic ramLayer;
		logic ramByte;
		// tile code latch enables
		logic capLo;
		logic capHi;
		// rom slot
		logic gfxValid;
		logic gfxLayer;
		logic gfxNibble;
	} fetchCtlT;

endpackage

// File: videoTimingPkg.sv
package videoTimingPkg;

	//////////////////////////////////////////////////
	// raster geometry
	//////////////////////////////////////////////////

	// horizontal pixel counter, 512 clocks per line max
	localparam int hBits = 9;

	// vertical line counter, 256 lines per frame max
	localparam int vBits = 8;

	// tiles are 8x8 pixels
	localparam int tileShift = 3;

	//////////////////////////////////////////////////
	// raster position
	//////////////////////////////////////////////////

	// current beam position, both counters together
	typedef struct packed {
		logic [hBits-1:0] hCount;
		logic [vBits-1:0] vCount;
	} rasterPosT;

endpackage
